/* common/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and pc width.
`define XLEN 32

`define REG_ADDR_W 5
`define NUM_REGS 32

// loads with this top nibble take a tlb refill.
`define UNMAPPED_SEG 4'hF

`endif

/* common/la_pkg.sv */
package la_pkg;

    // ********************
    // issue slot ops.
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_ld_w,
        op_syscall,
        op_brk,
        op_nop
    } alu_op_e;

    // estat ecode with esubcode bit 0 on top.
    typedef enum logic [6:0] {
        exp_none = 7'h00,
        exp_adef = 7'h08,
        exp_ale  = 7'h09,
        exp_sys  = 7'h0b,
        exp_brk  = 7'h0c,
        exp_tlbr = 7'h3f
    } exp_code_e;

    // setup and readback port.
    typedef enum logic [3:0] {
        csr_crmd,
        csr_prmd,
        csr_estat,
        csr_era,
        csr_badv,
        csr_eentry,
        csr_tlbrentry,
        csr_pgdl,
        csr_pgdh,
        csr_pgd
    } csr_sel_e;

endpackage

/* rtl/exec_pair.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module exec_pair (
    input  logic                   clk,
    input  logic                   rst_n,
    // issue slot 0.
    input  logic                   s0_valid,
    input  la_pkg::alu_op_e        s0_op,
    input  logic [`REG_ADDR_W-1:0] s0_rj, s0_rk, s0_rd,
    input  logic [`XLEN-1:0]       s0_imm, s0_pc, s0_inst,
    // issue slot 1.
    input  logic                   s1_valid,
    input  la_pkg::alu_op_e        s1_op,
    input  logic [`REG_ADDR_W-1:0] s1_rj, s1_rk, s1_rd,
    input  logic [`XLEN-1:0]       s1_imm, s1_pc, s1_inst,
    // register file.
    output logic [`REG_ADDR_W-1:0] raddr0, raddr1, raddr2, raddr3,
    input  logic [`XLEN-1:0]       rdata0, rdata1, rdata2, rdata3,
    // bundle committing this cycle.
    input  logic                   byp0_wen, byp1_wen,
    input  logic [`REG_ADDR_W-1:0] byp0_addr, byp1_addr,
    input  logic [`XLEN-1:0]       byp0_data, byp1_data,
    // to the pipeline latch.
    output logic                   e0_valid,
    output logic [`REG_ADDR_W-1:0] e0_rd,
    output logic [`XLEN-1:0]       e0_data, e0_pc, e0_inst,
    output la_pkg::exp_code_e      e0_exception,
    output logic [`XLEN-1:0]       e0_badv,
    output logic                   e1_valid,
    output logic [`REG_ADDR_W-1:0] e1_rd,
    output logic [`XLEN-1:0]       e1_data, e1_pc, e1_inst
);
    import la_pkg::*;

    logic [`XLEN-1:0] a0, b0;
    logic [`XLEN-1:0] a1, b1;

    // committing slot 1 is newer than slot 0.
    function automatic logic [`XLEN-1:0] fwd(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rf_val
    );
        if (byp1_wen && byp1_addr == addr) begin
            return byp1_data;
        end else if (byp0_wen && byp0_addr == addr) begin
            return byp0_data;
        end
        return rf_val;
    endfunction

    function automatic logic [`XLEN-1:0] alu(
        input alu_op_e          op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        case (op)
            op_add, op_ld_w: return a + b;  // load result is its address.
            op_sub:          return a - b;
            op_and:          return a & b;
            op_or:           return a | b;
            op_xor:          return a ^ b;
            op_sll:          return a << b[4:0];
            default:         return '0;
        endcase
    endfunction

    // ********************
    // operands.
    assign raddr0 = s0_rj;
    assign raddr1 = s0_rk;
    assign raddr2 = s1_rj;
    assign raddr3 = s1_rk;

    always_comb begin
        a0 = fwd(s0_rj, rdata0);
        b0 = (s0_op == op_ld_w) ? s0_imm : fwd(s0_rk, rdata1);
        a1 = fwd(s1_rj, rdata2);
        b1 = (s1_op == op_ld_w) ? s1_imm : fwd(s1_rk, rdata3);
    end

    assign e0_data = alu(s0_op, a0, b0);
    assign e1_data = alu(s1_op, a1, b1);

    assign e0_valid = s0_valid;
    assign e0_rd    = s0_rd;
    assign e0_pc    = s0_pc;
    assign e0_inst  = s0_inst;
    assign e1_valid = s1_valid;
    assign e1_rd    = s1_rd;
    assign e1_pc    = s1_pc;
    assign e1_inst  = s1_inst;

    // ********************
    // slot 0 exceptions, highest priority first.
    always_comb begin
        e0_exception = exp_none;
        e0_badv      = '0;
        if (s0_pc[1:0] != 2'b00) begin
            e0_exception = exp_adef;
            e0_badv      = s0_pc;
        end else if (s0_op == op_ld_w && e0_data[`XLEN-1 -: 4] == `UNMAPPED_SEG) begin
            e0_exception = exp_tlbr;
            e0_badv      = e0_data;
        end else if (s0_op == op_ld_w && e0_data[1:0] != 2'b00) begin
            e0_exception = exp_ale;
            e0_badv      = e0_data;
        end else if (s0_op == op_syscall) begin
            e0_exception = exp_sys;
        end else if (s0_op == op_brk) begin
            e0_exception = exp_brk;
        end
    end

    // issue never steers loads or traps to slot 1.
    a_s1_simple: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid |-> !(s1_op inside {op_ld_w, op_syscall, op_brk}));

endmodule

/* rtl/wb_latch.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module wb_latch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   e0_valid,
    input  logic [`REG_ADDR_W-1:0] e0_rd,
    input  logic [`XLEN-1:0]       e0_data, e0_pc, e0_inst,
    input  la_pkg::exp_code_e      e0_exception,
    input  logic [`XLEN-1:0]       e0_badv,
    input  logic                   e1_valid,
    input  logic [`REG_ADDR_W-1:0] e1_rd,
    input  logic [`XLEN-1:0]       e1_data, e1_pc, e1_inst,
    output logic                   w0_valid,
    output logic [`REG_ADDR_W-1:0] w0_rd,
    output logic [`XLEN-1:0]       w0_data, w0_pc, w0_inst,
    output la_pkg::exp_code_e      w0_exception,
    output logic [`XLEN-1:0]       w0_badv,
    output logic                   w1_valid,
    output logic [`REG_ADDR_W-1:0] w1_rd,
    output logic [`XLEN-1:0]       w1_data, w1_pc, w1_inst
);
    logic rst_done;

    // a redirect squashes the younger bundle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w0_valid <= 1'b0;
            w1_valid <= 1'b0;
        end else begin
            w0_valid <= e0_valid && !flush;
            w1_valid <= e1_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        w0_rd        <= e0_rd;
        w0_data      <= e0_data;
        w0_pc        <= e0_pc;
        w0_inst      <= e0_inst;
        w0_exception <= e0_exception;
        w0_badv      <= e0_badv;
        w1_rd        <= e1_rd;
        w1_data      <= e1_data;
        w1_pc        <= e1_pc;
        w1_inst      <= e1_inst;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_done <= 1'b1;  // stays set once reset is seen.
        end
    end

    a_w1_after_reset: assert property (@(posedge clk) $rose(w1_valid) |-> rst_done);

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] raddr0, raddr1, raddr2, raddr3,
    output logic [`XLEN-1:0]       rdata0, rdata1, rdata2, rdata3,
    input  logic                   wen0, wen1,
    input  logic [`REG_ADDR_W-1:0] waddr0, waddr1,
    input  logic [`XLEN-1:0]       wdata0, wdata1
);
    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0) begin
                regs[waddr0] <= wdata0;
            end
            if (wen1) begin
                regs[waddr1] <= wdata1;  // younger slot lands last.
            end
        end
    end

    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

    // writeback filters r0 targets.
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wen0 && waddr0 == '0) && !(wen1 && waddr1 == '0));

endmodule

/* writeback/writeback.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module writeback (
    input  logic                   w0_valid,
    input  logic [`REG_ADDR_W-1:0] w0_rd,
    input  logic [`XLEN-1:0]       w0_data, w0_pc, w0_inst,
    input  la_pkg::exp_code_e      w0_exception,
    input  logic [`XLEN-1:0]       w0_badv,
    input  logic                   w1_valid,
    input  logic [`REG_ADDR_W-1:0] w1_rd,
    input  logic [`XLEN-1:0]       w1_data, w1_pc, w1_inst,
    input  logic [`XLEN-1:0]       eentry, tlbrentry,
    // register file.
    output logic                   wen0, wen1,
    output logic [`REG_ADDR_W-1:0] waddr0, waddr1,
    output logic [`XLEN-1:0]       wdata0, wdata1,
    // pc redirect.
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_pc,
    // csr updates.
    output logic [`XLEN-1:0]       era,
    output logic                   era_wen,
    output logic                   store_state,
    output la_pkg::exp_code_e      expcode,
    output logic                   expcode_wen,
    output logic [`XLEN-1:0]       badv,
    output logic                   badv_wen,
    output logic                   pgd_wen,
    // debug trace.
    output logic [`XLEN-1:0]       debug0_wb_pc,
    output logic [3:0]             debug0_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug0_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug0_wb_rf_wdata, debug0_wb_inst,
    output logic [`XLEN-1:0]       debug1_wb_pc,
    output logic [3:0]             debug1_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug1_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug1_wb_rf_wdata, debug1_wb_inst
);
    import la_pkg::*;

    logic has_exc;
    logic set_badv;

    assign has_exc  = w0_valid && w0_exception != exp_none;
    assign set_badv = has_exc && (w0_exception inside {exp_adef, exp_ale, exp_tlbr});

    // ********************
    // exception entry.
    assign redirect    = has_exc;
    assign redirect_pc = (w0_exception == exp_tlbr) ? tlbrentry : eentry;
    assign era         = w0_pc;
    assign era_wen     = has_exc;
    assign store_state = has_exc;
    assign expcode     = w0_exception;
    assign expcode_wen = has_exc;
    assign badv        = w0_badv;
    assign badv_wen    = set_badv;
    assign pgd_wen     = set_badv;

    // slot 1 dies with a faulting slot 0.
    assign wen0   = w0_valid && !has_exc && w0_rd != '0;
    assign wen1   = w1_valid && !has_exc && w1_rd != '0;
    assign waddr0 = w0_rd;
    assign waddr1 = w1_rd;
    assign wdata0 = w0_data;
    assign wdata1 = w1_data;

    assign debug0_wb_pc       = w0_pc;
    assign debug0_wb_rf_wen   = {4{wen0}};
    assign debug0_wb_rf_wnum  = w0_rd;
    assign debug0_wb_rf_wdata = w0_data;
    assign debug0_wb_inst     = w0_inst;
    assign debug1_wb_pc       = w1_pc;
    assign debug1_wb_rf_wen   = {4{wen1}};
    assign debug1_wb_rf_wnum  = w1_rd;
    assign debug1_wb_rf_wdata = w1_data;
    assign debug1_wb_inst     = w1_inst;

endmodule

/* writeback/csr_file.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module csr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              csr_we,
    input  la_pkg::csr_sel_e  csr_sel,
    input  logic [`XLEN-1:0]  csr_wdata,
    output logic [`XLEN-1:0]  csr_rdata,
    input  logic [`XLEN-1:0]  era,
    input  logic              era_wen,
    input  logic              store_state,
    input  la_pkg::exp_code_e expcode,
    input  logic              expcode_wen,
    input  logic [`XLEN-1:0]  badv,
    input  logic              badv_wen,
    input  logic              pgd_wen,
    output logic [`XLEN-1:0]  eentry,
    output logic [`XLEN-1:0]  tlbrentry
);
    import la_pkg::*;

    localparam int IE_BIT    = 2;   // crmd ie, prmd pie.
    localparam int ECODE_LSB = 16;

    logic [`XLEN-1:0] crmd, prmd, estat;
    logic [`XLEN-1:0] era_r, badv_r;
    logic [`XLEN-1:0] pgdl, pgdh, pgd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd         <= '0;
            crmd[IE_BIT] <= 1'b1;
            prmd         <= '0;
            estat        <= '0;
            era_r        <= '0;
            badv_r       <= '0;
            eentry       <= '0;
            tlbrentry    <= '0;
            pgdl         <= '0;
            pgdh         <= '0;
            pgd          <= '0;
        end else begin
            if (csr_we) begin
                case (csr_sel)
                    csr_crmd:      crmd      <= csr_wdata;
                    csr_prmd:      prmd      <= csr_wdata;
                    csr_estat:     estat     <= csr_wdata;
                    csr_era:       era_r     <= csr_wdata;
                    csr_badv:      badv_r    <= csr_wdata;
                    csr_eentry:    eentry    <= csr_wdata;
                    csr_tlbrentry: tlbrentry <= csr_wdata;
                    csr_pgdl:      pgdl      <= csr_wdata;
                    csr_pgdh:      pgdh      <= csr_wdata;
                    csr_pgd:       pgd       <= csr_wdata;
                    default:       ;
                endcase
            end
            // ********************
            // exception updates, after the port so they win.
            if (store_state) begin
                prmd[IE_BIT] <= crmd[IE_BIT];
                crmd[IE_BIT] <= 1'b0;
            end
            if (era_wen) begin
                era_r <= era;
            end
            if (expcode_wen) begin
                estat[ECODE_LSB +: 7] <= expcode;
            end
            if (badv_wen) begin
                badv_r <= badv;
            end
            if (pgd_wen) begin
                pgd <= badv[31] ? pgdh : pgdl;  // high half for kernel space.
            end
        end
    end

    always_comb begin
        case (csr_sel)
            csr_crmd:      csr_rdata = crmd;
            csr_prmd:      csr_rdata = prmd;
            csr_estat:     csr_rdata = estat;
            csr_era:       csr_rdata = era_r;
            csr_badv:      csr_rdata = badv_r;
            csr_eentry:    csr_rdata = eentry;
            csr_tlbrentry: csr_rdata = tlbrentry;
            csr_pgdl:      csr_rdata = pgdl;
            csr_pgdh:      csr_rdata = pgdh;
            csr_pgd:       csr_rdata = pgd;
            default:       csr_rdata = '0;
        endcase
    end

endmodule

/* rtl/commit_top.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module commit_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   s0_valid,
    input  la_pkg::alu_op_e        s0_op,
    input  logic [`REG_ADDR_W-1:0] s0_rj, s0_rk, s0_rd,
    input  logic [`XLEN-1:0]       s0_imm, s0_pc, s0_inst,
    input  logic                   s1_valid,
    input  la_pkg::alu_op_e        s1_op,
    input  logic [`REG_ADDR_W-1:0] s1_rj, s1_rk, s1_rd,
    input  logic [`XLEN-1:0]       s1_imm, s1_pc, s1_inst,
    // csr setup and readback.
    input  logic                   csr_we,
    input  la_pkg::csr_sel_e       csr_sel,
    input  logic [`XLEN-1:0]       csr_wdata,
    output logic [`XLEN-1:0]       csr_rdata,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_pc,
    output logic [`XLEN-1:0]       debug0_wb_pc,
    output logic [3:0]             debug0_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug0_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug0_wb_rf_wdata, debug0_wb_inst,
    output logic [`XLEN-1:0]       debug1_wb_pc,
    output logic [3:0]             debug1_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug1_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug1_wb_rf_wdata, debug1_wb_inst
);
    import la_pkg::*;

    logic [`REG_ADDR_W-1:0] raddr0, raddr1, raddr2, raddr3;
    logic [`XLEN-1:0]       rdata0, rdata1, rdata2, rdata3;
    logic                   wen0, wen1;
    logic [`REG_ADDR_W-1:0] waddr0, waddr1;
    logic [`XLEN-1:0]       wdata0, wdata1;

    // execute to latch.
    logic                   e0_valid, e1_valid;
    logic [`REG_ADDR_W-1:0] e0_rd, e1_rd;
    logic [`XLEN-1:0]       e0_data, e0_pc, e0_inst, e0_badv;
    logic [`XLEN-1:0]       e1_data, e1_pc, e1_inst;
    exp_code_e              e0_exception;

    // latch to writeback.
    logic                   w0_valid, w1_valid;
    logic [`REG_ADDR_W-1:0] w0_rd, w1_rd;
    logic [`XLEN-1:0]       w0_data, w0_pc, w0_inst, w0_badv;
    logic [`XLEN-1:0]       w1_data, w1_pc, w1_inst;
    exp_code_e              w0_exception;

    logic [`XLEN-1:0]       era, badv, eentry, tlbrentry;
    logic                   era_wen, store_state, expcode_wen, badv_wen, pgd_wen;
    exp_code_e              expcode;

    exec_pair u_exec_pair (
        .byp0_wen  (wen0),
        .byp0_addr (waddr0),
        .byp0_data (wdata0),
        .byp1_wen  (wen1),
        .byp1_addr (waddr1),
        .byp1_data (wdata1),
        .*
    );

    wb_latch u_wb_latch (
        .flush (redirect),
        .*
    );

    reg_file u_reg_file (.*);

    writeback u_writeback (.*);

    csr_file u_csr_file (.*);

endmodule

/* verification/tb_commit.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module tb_commit;
    import la_pkg::*;

    localparam int NUM_RANDOM  = 200;
    localparam int NUM_BUNDLES = NUM_RANDOM + 120;  // setup, seeding and directed cases.

    typedef struct packed {
        logic                   v0, v1;
        logic [`XLEN-1:0]       pc0, pc1, inst0, inst1;
        logic                   wen0, wen1;
        logic [`REG_ADDR_W-1:0] wnum0, wnum1;
        logic [`XLEN-1:0]       wdata0, wdata1;
        logic                   redirect;
        logic [`XLEN-1:0]       redirect_pc;
    } exp_t;

    logic                   clk, rst_n;
    logic                   s0_valid, s1_valid;
    alu_op_e                s0_op, s1_op;
    logic [`REG_ADDR_W-1:0] s0_rj, s0_rk, s0_rd, s1_rj, s1_rk, s1_rd;
    logic [`XLEN-1:0]       s0_imm, s0_pc, s0_inst, s1_imm, s1_pc, s1_inst;
    logic                   csr_we;
    csr_sel_e               csr_sel;
    logic [`XLEN-1:0]       csr_wdata, csr_rdata;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic [`XLEN-1:0]       debug0_wb_pc, debug0_wb_rf_wdata, debug0_wb_inst;
    logic [`XLEN-1:0]       debug1_wb_pc, debug1_wb_rf_wdata, debug1_wb_inst;
    logic [3:0]             debug0_wb_rf_wen, debug1_wb_rf_wen;
    logic [`REG_ADDR_W-1:0] debug0_wb_rf_wnum, debug1_wb_rf_wnum;

    // ********************
    // reference state.
    logic [`XLEN-1:0] m_regs [32];
    logic             m_ie, m_pie, m_flush;
    exp_code_e        m_ecode;
    logic [`XLEN-1:0] m_era, m_badv, m_pgd;
    logic [`XLEN-1:0] m_eentry, m_tlbrentry, m_pgdl, m_pgdh;

    exp_t   exp_q [$];
    exp_t   cur;
    integer seed = 32'h85a3_3b3d;
    int     err_count = 0;

    commit_top DUT (.*);

    always #2 clk = ~clk;

    task automatic abort_run();
        err_count++;
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exp(input string name, input exp_code_e got, input exp_code_e exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [`XLEN-1:0] alu_ref(input alu_op_e op,
                                                 input logic [`XLEN-1:0] a, b);
        logic [`XLEN-1:0] r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sll:  r = a << b[4:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    // runs one bundle through the model in issue order.
    function automatic exp_t ref_exec(
        input logic v0, input alu_op_e op0, input logic [`REG_ADDR_W-1:0] rj0, rk0, rd0,
        input logic [`XLEN-1:0] imm0, pc0,
        input logic v1, input alu_op_e op1, input logic [`REG_ADDR_W-1:0] rj1, rk1, rd1,
        input logic [`XLEN-1:0] pc1
    );
        exp_t             e;
        logic [`XLEN-1:0] res0, res1, addr, bad;
        exp_code_e        exc;
        e = '0;
        if (m_flush) begin
            m_flush = 1'b0;  // squashed by the redirect ahead of it.
            return e;
        end
        e.v0  = v0;
        e.v1  = v1;
        e.pc0 = pc0;
        e.pc1 = pc1;
        addr  = m_regs[rj0] + imm0;
        res0  = (op0 == op_ld_w) ? addr : alu_ref(op0, m_regs[rj0], m_regs[rk0]);
        res1  = alu_ref(op1, m_regs[rj1], m_regs[rk1]);
        exc   = exp_none;
        bad   = '0;
        if (v0) begin
            if (pc0[1:0] != 2'b00) begin
                exc = exp_adef;
                bad = pc0;
            end else if (op0 == op_ld_w && addr[31:28] == `UNMAPPED_SEG) begin
                exc = exp_tlbr;
                bad = addr;
            end else if (op0 == op_ld_w && addr[1:0] != 2'b00) begin
                exc = exp_ale;
                bad = addr;
            end else if (op0 == op_syscall) begin
                exc = exp_sys;
            end else if (op0 == op_brk) begin
                exc = exp_brk;
            end
        end
        if (exc != exp_none) begin
            e.redirect    = 1'b1;
            e.redirect_pc = (exc == exp_tlbr) ? m_tlbrentry : m_eentry;
            m_era   = pc0;
            m_ecode = exc;
            m_pie   = m_ie;
            m_ie    = 1'b0;
            if (exc inside {exp_adef, exp_ale, exp_tlbr}) begin
                m_badv = bad;
                m_pgd  = bad[31] ? m_pgdh : m_pgdl;
            end
            m_flush = 1'b1;
            return e;
        end
        e.wen0   = v0 && rd0 != '0;
        e.wnum0  = rd0;
        e.wdata0 = res0;
        e.wen1   = v1 && rd1 != '0;
        e.wnum1  = rd1;
        e.wdata1 = res1;
        if (e.wen0) m_regs[rd0] = res0;
        if (e.wen1) m_regs[rd1] = res1;  // slot 1 lands last.
        return e;
    endfunction

    task automatic issue(
        input logic v0, input alu_op_e op0, input logic [`REG_ADDR_W-1:0] rj0, rk0, rd0,
        input logic [`XLEN-1:0] imm0, pc0,
        input logic v1, input alu_op_e op1, input logic [`REG_ADDR_W-1:0] rj1, rk1, rd1
    );
        exp_t e;
        @(negedge clk);
        csr_we   = 1'b0;
        s0_valid = v0;
        s0_op    = op0;
        s0_rj    = rj0;
        s0_rk    = rk0;
        s0_rd    = rd0;
        s0_imm   = imm0;
        s0_pc    = pc0;
        s0_inst  = $random(seed);
        s1_valid = v1;
        s1_op    = op1;
        s1_rj    = rj1;
        s1_rk    = rk1;
        s1_rd    = rd1;
        s1_imm   = $random(seed);
        s1_pc    = pc0 + 4;
        s1_inst  = $random(seed);
        e = ref_exec(v0, op0, rj0, rk0, rd0, imm0, pc0, v1, op1, rj1, rk1, rd1, s1_pc);
        e.inst0 = s0_inst;
        e.inst1 = s1_inst;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        repeat (2) issue(1'b0, op_add, '0, '0, '0, '0, '0, 1'b0, op_add, '0, '0, '0);
    endtask

    task automatic write_csr(input csr_sel_e sel, input logic [`XLEN-1:0] data);
        @(negedge clk);
        s0_valid  = 1'b0;
        s1_valid  = 1'b0;
        csr_we    = 1'b1;
        csr_sel   = sel;
        csr_wdata = data;
        case (sel)
            csr_crmd:      m_ie = data[2];
            csr_eentry:    m_eentry = data;
            csr_tlbrentry: m_tlbrentry = data;
            csr_pgdl:      m_pgdl = data;
            csr_pgdh:      m_pgdh = data;
            default:       ;
        endcase
    endtask

    task automatic read_csr(input csr_sel_e sel, output logic [`XLEN-1:0] val);
        @(negedge clk);
        s0_valid = 1'b0;
        s1_valid = 1'b0;
        csr_we   = 1'b0;
        csr_sel  = sel;
        #1;
        val = csr_rdata;
    endtask

    task automatic verify_csrs();
        logic [`XLEN-1:0] v;
        read_csr(csr_era, v);
        check_word("era", v, m_era);
        read_csr(csr_estat, v);
        check_exp("estat_ecode", exp_code_e'(v[22:16]), m_ecode);
        read_csr(csr_badv, v);
        check_word("badv", v, m_badv);
        read_csr(csr_pgd, v);
        check_word("pgd", v, m_pgd);
        read_csr(csr_prmd, v);
        check_bit("prmd_pie", v[2], m_pie);
        read_csr(csr_crmd, v);
        check_bit("crmd_ie", v[2], m_ie);
    endtask

    // a faulting bundle and the bundle it squashes.
    task automatic run_exception(input alu_op_e op, input logic [`XLEN-1:0] imm, epc);
        drain();
        write_csr(csr_crmd, 32'h0000_0004);
        issue(1'b1, op, 5'd0, 5'd0, 5'd5, imm, epc, 1'b1, op_add, 5'd1, 5'd2, 5'd6);
        issue(1'b1, op_add, 5'd1, 5'd2, 5'd7, '0, epc + 8, 1'b1, op_or, 5'd3, 5'd4, 5'd8);
        drain();
        verify_csrs();
    endtask

    function automatic logic [`REG_ADDR_W-1:0] rnd_reg();
        return 5'($unsigned($random(seed)) % 16);
    endfunction

    function automatic logic rnd_valid();
        return ($random(seed) & 7) != 0;
    endfunction

    // ********************
    // compare one cycle after issue.
    always @(posedge clk) begin
        #1;
        if (exp_q.size() > 0) begin
            cur = exp_q.pop_front();
            check_bit("redirect", redirect, cur.redirect);
            if (cur.redirect) begin
                check_word("redirect_pc", redirect_pc, cur.redirect_pc);
            end
            check_word("debug0_wb_rf_wen", 32'(debug0_wb_rf_wen), cur.wen0 ? 32'hf : 32'h0);
            check_word("debug1_wb_rf_wen", 32'(debug1_wb_rf_wen), cur.wen1 ? 32'hf : 32'h0);
            if (cur.wen0) begin
                check_word("debug0_wb_rf_wnum", 32'(debug0_wb_rf_wnum), 32'(cur.wnum0));
                check_word("debug0_wb_rf_wdata", debug0_wb_rf_wdata, cur.wdata0);
            end
            if (cur.wen1) begin
                check_word("debug1_wb_rf_wnum", 32'(debug1_wb_rf_wnum), 32'(cur.wnum1));
                check_word("debug1_wb_rf_wdata", debug1_wb_rf_wdata, cur.wdata1);
            end
            if (cur.v0) begin
                check_word("debug0_wb_pc", debug0_wb_pc, cur.pc0);
                check_word("debug0_wb_inst", debug0_wb_inst, cur.inst0);
            end
            if (cur.v1) begin
                check_word("debug1_wb_pc", debug1_wb_pc, cur.pc1);
                check_word("debug1_wb_inst", debug1_wb_inst, cur.inst1);
            end
        end
    end

    initial begin
        #(NUM_BUNDLES * 4 * 4);
        $display("timeout: the run took longer than %0d ns", NUM_BUNDLES * 16);
        abort_run();
    end

    initial begin
        alu_op_e          op0, op1;
        logic [`XLEN-1:0] imm0, pc;
        clk       = 1'b0;
        rst_n     = 1'b0;
        s0_valid  = 1'b0;
        s0_op     = op_nop;
        s0_rj     = '0;
        s0_rk     = '0;
        s0_rd     = '0;
        s0_imm    = '0;
        s0_pc     = '0;
        s0_inst   = '0;
        s1_valid  = 1'b0;
        s1_op     = op_nop;
        s1_rj     = '0;
        s1_rk     = '0;
        s1_rd     = '0;
        s1_imm    = '0;
        s1_pc     = '0;
        s1_inst   = '0;
        csr_we    = 1'b0;
        csr_sel   = csr_crmd;
        csr_wdata = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
        m_ie        = 1'b1;
        m_pie       = 1'b0;
        m_flush     = 1'b0;
        m_ecode     = exp_none;
        m_era       = '0;
        m_badv      = '0;
        m_pgd       = '0;
        m_eentry    = '0;
        m_tlbrentry = '0;
        m_pgdl      = '0;
        m_pgdh      = '0;
        pc          = 32'h1c00_0000;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        write_csr(csr_eentry, 32'h1c00_8000);
        write_csr(csr_tlbrentry, 32'h1c00_f000);
        write_csr(csr_pgdl, 32'h0012_3000);
        write_csr(csr_pgdh, 32'h8045_6000);

        // aligned seed values through load addresses.
        for (int r = 1; r < 16; r++) begin
            imm0 = $random(seed) & 32'h7fff_fffc;
            issue(1'b1, op_ld_w, 5'd0, 5'd0, 5'(r), imm0, pc, 1'b0, op_add, '0, '0, '0);
            pc += 8;
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            op0  = alu_op_e'(4'($unsigned($random(seed)) % 7));
            op1  = alu_op_e'(4'($unsigned($random(seed)) % 6));
            imm0 = $random(seed);
            if (imm0[5:3] != 3'b000) imm0[1:0] = 2'b00;  // misaligned now and then.
            issue(rnd_valid(), op0, rnd_reg(), rnd_reg(), rnd_reg(), imm0, pc,
                  rnd_valid(), op1, rnd_reg(), rnd_reg(), rnd_reg());
            pc += 8;
        end
        drain();
        verify_csrs();

        // ********************
        // back to back bundles read through the bypass.
        issue(1'b1, op_add, 5'd1, 5'd2, 5'd10, '0, pc, 1'b1, op_xor, 5'd3, 5'd4, 5'd11);
        issue(1'b1, op_sub, 5'd10, 5'd11, 5'd12, '0, pc + 8, 1'b1, op_add, 5'd11, 5'd10, 5'd13);
        issue(1'b1, op_add, 5'd12, 5'd1, 5'd14, '0, pc + 16, 1'b1, op_or, 5'd13, 5'd2, 5'd14);
        issue(1'b1, op_sll, 5'd14, 5'd3, 5'd15, '0, pc + 24, 1'b1, op_and, 5'd14, 5'd12, 5'd0);

        // pgd alternates between halves so each update shows.
        run_exception(op_ld_w, 32'h0000_2001, 32'h1c00_1000);
        run_exception(op_ld_w, 32'h8000_0103, 32'h1c00_1040);
        run_exception(op_add, '0, 32'h1c00_1202);
        run_exception(op_ld_w, 32'hf000_0010, 32'h1c00_1100);
        run_exception(op_syscall, '0, 32'h1c00_1300);
        run_exception(op_brk, '0, 32'h1c00_1400);

        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+common
common/la_pkg.sv
rtl/exec_pair.sv
rtl/wb_latch.sv
rtl/reg_file.sv
writeback/writeback.sv
writeback/csr_file.sv
rtl/commit_top.sv
verification/tb_commit.sv

/* Makefile */
SIM      := verilator
VFLAGS   := --binary --timing --assert -j 0
TOP      := tb_commit
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) common/core_config.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
